//--- hdl/rd_port_pkg.sv
package rd_port_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Byte count of one read command
    localparam int BYTE_W = 32;

    // Relay queues supported by the read engine
    localparam int QUEUE_NUM = 8;

    // Wide enough for any queue number
    localparam int QUEUE_W = 3;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // Read length in bytes
    typedef logic [BYTE_W-1:0] byte_cnt_t;

    // Target queue of a read
    typedef logic [QUEUE_W-1:0] queue_id_t;

    // Phases of one read round, issued in this order
    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_UNLOCAL = 2'd1,
        PH_LOCAL   = 2'd2,
        PH_RELAY   = 2'd3
    } rd_phase_t;

endpackage

//--- hdl/rd_desc_if.sv
`timescale 1ns/1ns

interface rd_desc_if;

    import rd_port_pkg::*;

    // Unlocal direct descriptor
    logic      unl_valid;
    byte_cnt_t unl_bytes;
    queue_id_t unl_queue;

    // Local direct descriptor
    logic      loc_valid;
    byte_cnt_t loc_bytes;
    queue_id_t loc_queue;

    modport capture (
        output unl_valid, unl_bytes, unl_queue,
        output loc_valid, loc_bytes, loc_queue
    );

    modport seq (
        input unl_valid, unl_bytes, unl_queue,
        input loc_valid, loc_bytes, loc_queue
    );

endinterface

//--- hdl/rd_cmd_if.sv
`timescale 1ns/1ns

interface rd_cmd_if;

    import rd_port_pkg::*;

    // Request from the sequencer, held while work remains in the phase
    logic      req;
    logic      flag;
    queue_id_t queue;
    byte_cnt_t bytes;

    // One-cycle pulse on the detected finish edge
    logic      done;

    modport seq (
        output req, flag, queue, bytes,
        input  done
    );

    modport issue (
        input  req, flag, queue, bytes,
        output done
    );

endinterface

//--- hdl/rd_req_capture.sv
`timescale 1ns/1ns

module rd_req_capture (
    input  logic                  i_clk,
    input  logic                  i_rst,

    input  logic                  i_unl_valid,
    input  rd_port_pkg::byte_cnt_t i_unl_bytes,
    input  rd_port_pkg::queue_id_t i_unl_queue,

    input  logic                  i_loc_valid,
    input  rd_port_pkg::byte_cnt_t i_loc_bytes,
    input  rd_port_pkg::queue_id_t i_loc_queue,

    input  rd_port_pkg::rd_phase_t i_phase,

    rd_desc_if.capture            desc
);

    import rd_port_pkg::*;

    ////////////////////////////////////////
    // Unlocal descriptor
    ////////////////////////////////////////

    // Accepted in any phase, dropped once the local phase is reached
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            desc.unl_valid <= 1'b0;
        end else if (i_unl_valid) begin
            desc.unl_valid <= 1'b1;
        end else if (i_phase == PH_LOCAL) begin
            desc.unl_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_unl_valid) begin
            desc.unl_bytes <= i_unl_bytes;
            desc.unl_queue <= i_unl_queue;
        end
    end

    ////////////////////////////////////////
    // Local descriptor
    ////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            desc.loc_valid <= 1'b0;
        end else if (i_phase == PH_IDLE) begin
            desc.loc_valid <= 1'b0;
        end else if (i_loc_valid) begin
            desc.loc_valid <= 1'b1;
        end
    end

    // Ignored between rounds
    always_ff @(posedge i_clk) begin
        if (i_loc_valid && i_phase != PH_IDLE) begin
            desc.loc_bytes <= i_loc_bytes;
            desc.loc_queue <= i_loc_queue;
        end
    end

endmodule

//--- hdl/rd_relay_table.sv
`timescale 1ns/1ns

module rd_relay_table #(
    parameter int P_RELAY_QUEUES = rd_port_pkg::QUEUE_NUM
) (
    input  logic                                          i_clk,
    input  logic                                          i_rst,

    input  logic                                          i_relay_valid,
    input  logic [P_RELAY_QUEUES*rd_port_pkg::BYTE_W-1:0] i_relay_bytes,

    input  rd_port_pkg::rd_phase_t                        i_phase,
    input  logic                                          i_done,

    output logic                                          o_relay_pending,
    output rd_port_pkg::queue_id_t                        o_sel_queue,
    output rd_port_pkg::byte_cnt_t                        o_sel_bytes
);

    import rd_port_pkg::*;

    byte_cnt_t                 r_counts [P_RELAY_QUEUES];
    logic [P_RELAY_QUEUES-1:0] r_pending;
    logic                      w_load;

    assign w_load = i_relay_valid && (i_phase != PH_IDLE);

    ////////////////////////////////////////
    // Byte counts per queue
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (w_load) begin
            for (int i = 0; i < P_RELAY_QUEUES; i++) begin
                r_counts[i] <= i_relay_bytes[i*BYTE_W +: BYTE_W];
            end
        end
    end

    ////////////////////////////////////////
    // Pending bits
    ////////////////////////////////////////

    // Zero counts never become pending, so they are never issued
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_pending <= '0;
        end else if (i_phase == PH_IDLE) begin
            r_pending <= '0;
        end else if (w_load) begin
            for (int i = 0; i < P_RELAY_QUEUES; i++) begin
                r_pending[i] <= (i_relay_bytes[i*BYTE_W +: BYTE_W] != '0);
            end
        end else if (i_done && i_phase == PH_RELAY && o_relay_pending) begin
            r_pending[o_sel_queue] <= 1'b0;
        end
    end

    assign o_relay_pending = |r_pending;

    // Lowest pending index wins, scan runs downward
    always_comb begin
        o_sel_queue = '0;
        o_sel_bytes = '0;
        for (int i = P_RELAY_QUEUES - 1; i >= 0; i--) begin
            if (r_pending[i]) begin
                o_sel_queue = queue_id_t'(i);
                o_sel_bytes = r_counts[i];
            end
        end
    end

endmodule

//--- hdl/rd_phase_seq.sv
`timescale 1ns/1ns

module rd_phase_seq (
    input  logic                   i_clk,
    input  logic                   i_rst,

    rd_desc_if.seq                 desc,

    input  logic                   i_relay_pending,
    input  rd_port_pkg::queue_id_t i_sel_queue,
    input  rd_port_pkg::byte_cnt_t i_sel_bytes,

    output rd_port_pkg::rd_phase_t o_phase,

    rd_cmd_if.seq                  cmd
);

    import rd_port_pkg::*;

    rd_phase_t r_phase;
    rd_phase_t w_next;
    logic      w_unl_zero;
    logic      w_loc_zero;

    assign w_unl_zero = (desc.unl_bytes == '0);
    assign w_loc_zero = (desc.loc_bytes == '0);
    assign o_phase    = r_phase;

    ////////////////////////////////////////
    // Phase FSM
    ////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_phase <= PH_IDLE;
        end else begin
            r_phase <= w_next;
        end
    end

    always_comb begin
        w_next = r_phase;
        case (r_phase)
            PH_IDLE: begin
                if (desc.unl_valid) begin
                    w_next = PH_UNLOCAL;
                end
            end
            PH_UNLOCAL: begin
                if (w_unl_zero || cmd.done) begin
                    w_next = PH_LOCAL;
                end
            end
            PH_LOCAL: begin
                if (desc.loc_valid && (w_loc_zero || cmd.done)) begin
                    w_next = PH_RELAY;
                end
            end
            PH_RELAY: begin
                if (!i_relay_pending) begin
                    w_next = PH_IDLE;
                end
            end
            default: w_next = PH_IDLE;
        endcase
    end

    // Command source follows the phase
    always_comb begin
        cmd.req   = 1'b0;
        cmd.flag  = 1'b0;
        cmd.queue = '0;
        cmd.bytes = '0;
        case (r_phase)
            PH_UNLOCAL: begin
                cmd.req   = desc.unl_valid && !w_unl_zero;
                cmd.flag  = 1'b1;
                cmd.queue = desc.unl_queue;
                cmd.bytes = desc.unl_bytes;
            end
            PH_LOCAL: begin
                cmd.req   = desc.loc_valid && !w_loc_zero;
                cmd.queue = desc.loc_queue;
                cmd.bytes = desc.loc_bytes;
            end
            PH_RELAY: begin
                cmd.req   = i_relay_pending;
                cmd.queue = i_sel_queue;
                cmd.bytes = i_sel_bytes;
            end
            default: ;
        endcase
    end

endmodule

//--- hdl/rd_cmd_issue.sv
`timescale 1ns/1ns

module rd_cmd_issue #(
    parameter int P_SYNC_STAGES = 2
) (
    input  logic                   i_clk,
    input  logic                   i_rst,

    rd_cmd_if.issue                cmd,

    input  logic                   i_rd_byte_ready,
    input  logic                   i_rd_queue_finish,

    output logic                   o_rd_flag,
    output rd_port_pkg::queue_id_t o_rd_queue,
    output rd_port_pkg::byte_cnt_t o_rd_byte,
    output logic                   o_rd_byte_valid
);

    // One extra stage past the synchronizer keeps the previous value
    logic [P_SYNC_STAGES:0] r_ready_sync;
    logic [P_SYNC_STAGES:0] r_finish_sync;
    logic                   w_ready_rise;
    logic                   w_finish_rise;
    logic                   w_take;
    logic                   r_busy;

    ////////////////////////////////////////
    // Synchronizers and edge detect
    ////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_ready_sync  <= '0;
            r_finish_sync <= '0;
        end else begin
            r_ready_sync  <= {r_ready_sync[P_SYNC_STAGES-1:0], i_rd_byte_ready};
            r_finish_sync <= {r_finish_sync[P_SYNC_STAGES-1:0], i_rd_queue_finish};
        end
    end

    assign w_ready_rise  = r_ready_sync[P_SYNC_STAGES-1] & ~r_ready_sync[P_SYNC_STAGES];
    assign w_finish_rise = r_finish_sync[P_SYNC_STAGES-1] & ~r_finish_sync[P_SYNC_STAGES];

    assign cmd.done = w_finish_rise;

    ////////////////////////////////////////
    // Command register
    ////////////////////////////////////////

    assign w_take = cmd.req && !r_busy;

    // Busy spans from the take until the engine reports finish
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_busy <= 1'b0;
        end else if (w_take) begin
            r_busy <= 1'b1;
        end else if (w_finish_rise) begin
            r_busy <= 1'b0;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_rd_byte_valid <= 1'b0;
        end else if (w_take) begin
            o_rd_byte_valid <= 1'b1;
        end else if (w_ready_rise) begin
            o_rd_byte_valid <= 1'b0;
        end
    end

    // Fields hold through the read, cleared when nothing is held
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_rd_flag  <= 1'b0;
            o_rd_queue <= '0;
            o_rd_byte  <= '0;
        end else if (w_take) begin
            o_rd_flag  <= cmd.flag;
            o_rd_queue <= cmd.queue;
            o_rd_byte  <= cmd.bytes;
        end else if (!r_busy) begin
            o_rd_flag  <= 1'b0;
            o_rd_queue <= '0;
            o_rd_byte  <= '0;
        end
    end

endmodule

//--- hdl/rd_port_ctrl.sv
`timescale 1ns/1ns

module rd_port_ctrl #(
    parameter int P_RELAY_QUEUES = rd_port_pkg::QUEUE_NUM,
    parameter int P_SYNC_STAGES  = 2
) (
    input  logic                                          i_clk,
    input  logic                                          i_rst,

    input  logic                                          i_unl_valid,
    input  rd_port_pkg::byte_cnt_t                        i_unl_bytes,
    input  rd_port_pkg::queue_id_t                        i_unl_queue,

    input  logic                                          i_loc_valid,
    input  rd_port_pkg::byte_cnt_t                        i_loc_bytes,
    input  rd_port_pkg::queue_id_t                        i_loc_queue,

    input  logic                                          i_relay_valid,
    input  logic [P_RELAY_QUEUES*rd_port_pkg::BYTE_W-1:0] i_relay_bytes,

    input  logic                                          i_rd_byte_ready,
    input  logic                                          i_rd_queue_finish,

    output logic                                          o_rd_flag,
    output rd_port_pkg::queue_id_t                        o_rd_queue,
    output rd_port_pkg::byte_cnt_t                        o_rd_byte,
    output logic                                          o_rd_byte_valid
);

    import rd_port_pkg::*;

    rd_phase_t w_phase;
    logic      w_relay_pending;
    queue_id_t w_sel_queue;
    byte_cnt_t w_sel_bytes;

    rd_desc_if u_desc_if ();
    rd_cmd_if  u_cmd_if ();

    rd_req_capture u_rd_req_capture (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_unl_valid (i_unl_valid),
        .i_unl_bytes (i_unl_bytes),
        .i_unl_queue (i_unl_queue),
        .i_loc_valid (i_loc_valid),
        .i_loc_bytes (i_loc_bytes),
        .i_loc_queue (i_loc_queue),
        .i_phase     (w_phase),
        .desc        (u_desc_if.capture)
    );

    // Finish pulse also retires the selected relay queue
    rd_relay_table #(
        .P_RELAY_QUEUES (P_RELAY_QUEUES)
    ) u_rd_relay_table (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_relay_valid   (i_relay_valid),
        .i_relay_bytes   (i_relay_bytes),
        .i_phase         (w_phase),
        .i_done          (u_cmd_if.done),
        .o_relay_pending (w_relay_pending),
        .o_sel_queue     (w_sel_queue),
        .o_sel_bytes     (w_sel_bytes)
    );

    rd_phase_seq u_rd_phase_seq (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .desc            (u_desc_if.seq),
        .i_relay_pending (w_relay_pending),
        .i_sel_queue     (w_sel_queue),
        .i_sel_bytes     (w_sel_bytes),
        .o_phase         (w_phase),
        .cmd             (u_cmd_if.seq)
    );

    rd_cmd_issue #(
        .P_SYNC_STAGES (P_SYNC_STAGES)
    ) u_rd_cmd_issue (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .cmd               (u_cmd_if.issue),
        .i_rd_byte_ready   (i_rd_byte_ready),
        .i_rd_queue_finish (i_rd_queue_finish),
        .o_rd_flag         (o_rd_flag),
        .o_rd_queue        (o_rd_queue),
        .o_rd_byte         (o_rd_byte),
        .o_rd_byte_valid   (o_rd_byte_valid)
    );

endmodule

//--- test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic o_clk,
    output logic o_rst
);

    localparam int HALF_PERIOD = 20;
    localparam int RST_CYCLES  = 16;

    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_PERIOD o_clk = ~o_clk;
        end
    end

    // Released on a falling edge, clear of drive and sample points
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;
    end

endmodule

//--- test/tb_rd_port_ctrl.sv
`timescale 1ns/1ns

module tb_rd_port_ctrl;

    import rd_port_pkg::*;

    localparam int RELAY_QUEUES = 8;
    localparam int SYNC_STAGES  = 2;
    localparam int ROUNDS       = 40;
    localparam int TIMEOUT      = 2000;
    localparam int DRIVE_DLY    = 2;

    // Round whose relay counts are all zero
    localparam int ZERO_RELAY_ROUND = 7;

    typedef struct packed {
        logic      flag;
        queue_id_t queue;
        byte_cnt_t bytes;
    } rd_cmd_t;

    logic                             clk;
    logic                             rst;
    logic                             i_unl_valid;
    byte_cnt_t                        i_unl_bytes;
    queue_id_t                        i_unl_queue;
    logic                             i_loc_valid;
    byte_cnt_t                        i_loc_bytes;
    queue_id_t                        i_loc_queue;
    logic                             i_relay_valid;
    logic [RELAY_QUEUES*BYTE_W-1:0]   i_relay_bytes;
    logic                             i_rd_byte_ready;
    logic                             i_rd_queue_finish;
    logic                             o_rd_flag;
    queue_id_t                        o_rd_queue;
    byte_cnt_t                        o_rd_byte;
    logic                             o_rd_byte_valid;

    integer  seed = 85794;
    rd_cmd_t exp_q[$];
    logic    prev_valid = 1'b0;
    logic    resp_busy = 1'b0;
    int      cmd_cnt = 0;
    int      ready_cnt = 0;
    int      finish_cnt = 0;

    tb_clk_gen u_tb_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    rd_port_ctrl #(
        .P_RELAY_QUEUES (RELAY_QUEUES),
        .P_SYNC_STAGES  (SYNC_STAGES)
    ) u_rd_port_ctrl (
        .i_clk             (clk),
        .i_rst             (rst),
        .i_unl_valid       (i_unl_valid),
        .i_unl_bytes       (i_unl_bytes),
        .i_unl_queue       (i_unl_queue),
        .i_loc_valid       (i_loc_valid),
        .i_loc_bytes       (i_loc_bytes),
        .i_loc_queue       (i_loc_queue),
        .i_relay_valid     (i_relay_valid),
        .i_relay_bytes     (i_relay_bytes),
        .i_rd_byte_ready   (i_rd_byte_ready),
        .i_rd_queue_finish (i_rd_queue_finish),
        .o_rd_flag         (o_rd_flag),
        .o_rd_queue        (o_rd_queue),
        .o_rd_byte         (o_rd_byte),
        .o_rd_byte_valid   (o_rd_byte_valid)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic value_error(input string msg);
        fail_run($sformatf("[ERROR] %0t ns %s", $time, msg));
    endtask

    // Zero about one time in four
    function automatic byte_cnt_t pick_bytes();
        byte_cnt_t v;
        v = $random(seed);
        if (v[1:0] == 2'b00) begin
            return '0;
        end
        v = $random(seed);
        if (v == '0) begin
            v = 32'd1;
        end
        return v;
    endfunction

    task automatic check_command(input rd_cmd_t exp);
        assert (o_rd_flag == exp.flag) else
            value_error($sformatf("flag %0b, expected %0b", o_rd_flag, exp.flag));
        assert (o_rd_queue == exp.queue) else
            value_error($sformatf("queue %0d, expected %0d", o_rd_queue, exp.queue));
        assert (o_rd_byte == exp.bytes) else
            value_error($sformatf("bytes %0h, expected %0h", o_rd_byte, exp.bytes));
    endtask

    ////////////////////////////////////////
    // Command monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (o_rd_byte_valid && !prev_valid) begin
            assert (finish_cnt == cmd_cnt) else
                value_error("new command before finish of the previous one");
            assert (cmd_cnt < exp_q.size()) else
                value_error("command issued that the model does not expect");
            check_command(exp_q[cmd_cnt]);
            cmd_cnt = cmd_cnt + 1;
        end else if (o_rd_byte_valid) begin
            // Fields must not move while the command is offered
            check_command(exp_q[cmd_cnt - 1]);
        end else if (prev_valid) begin
            assert (ready_cnt == cmd_cnt) else
                value_error("o_rd_byte_valid dropped before ready was raised");
        end
        prev_valid = o_rd_byte_valid;
    end

    ////////////////////////////////////////
    // Read engine responder
    ////////////////////////////////////////

    initial begin : responder
        int cnt;
        int gap;
        i_rd_byte_ready   = 1'b0;
        i_rd_queue_finish = 1'b0;
        forever begin
            cnt = 0;
            while (o_rd_byte_valid !== 1'b1) begin
                next_cycle();
                cnt = cnt + 1;
                if (cnt > TIMEOUT) begin
                    fail_run("Timeout: the DUT issued no read command");
                end
            end
            resp_busy = 1'b1;
            gap = {$random(seed)} % 7;
            repeat (gap) next_cycle();
            i_rd_byte_ready = 1'b1;
            ready_cnt = ready_cnt + 1;
            repeat (4) next_cycle();
            i_rd_byte_ready = 1'b0;
            gap = {$random(seed)} % 8 + 1;
            repeat (gap) next_cycle();
            i_rd_queue_finish = 1'b1;
            finish_cnt = finish_cnt + 1;
            repeat (4) next_cycle();
            i_rd_queue_finish = 1'b0;
            resp_busy = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Rounds
    ////////////////////////////////////////

    initial begin : stimulus
        int        cnt;
        byte_cnt_t rbytes;
        i_unl_valid   = 1'b0;
        i_unl_bytes   = '0;
        i_unl_queue   = '0;
        i_loc_valid   = 1'b0;
        i_loc_bytes   = '0;
        i_loc_queue   = '0;
        i_relay_valid = 1'b0;
        i_relay_bytes = '0;

        cnt = 0;
        next_cycle();
        while (rst) begin
            next_cycle();
            cnt = cnt + 1;
            if (cnt > TIMEOUT) begin
                fail_run("Timeout: reset was never released");
            end
        end
        assert (o_rd_byte_valid == 1'b0 && o_rd_flag == 1'b0 &&
                o_rd_queue == '0 && o_rd_byte == '0) else
            value_error("command outputs not zero after reset");

        for (int r = 0; r < ROUNDS; r++) begin
            i_unl_bytes = pick_bytes();
            i_unl_queue = queue_id_t'($random(seed));
            i_loc_bytes = pick_bytes();
            i_loc_queue = queue_id_t'($random(seed));

            // Expected order: unlocal, local, then relays from queue 0 up
            if (i_unl_bytes != '0) begin
                exp_q.push_back({1'b1, i_unl_queue, i_unl_bytes});
            end
            if (i_loc_bytes != '0) begin
                exp_q.push_back({1'b0, i_loc_queue, i_loc_bytes});
            end
            for (int q = 0; q < RELAY_QUEUES; q++) begin
                rbytes = pick_bytes();
                if (r == ZERO_RELAY_ROUND) begin
                    rbytes = '0;
                end
                i_relay_bytes[q*BYTE_W +: BYTE_W] = rbytes;
                if (rbytes != '0) begin
                    exp_q.push_back({1'b0, queue_id_t'(q), rbytes});
                end
            end

            i_unl_valid = 1'b1;
            next_cycle();
            i_unl_valid = 1'b0;
            repeat (3) next_cycle();
            i_loc_valid   = 1'b1;
            i_relay_valid = 1'b1;
            next_cycle();
            i_loc_valid   = 1'b0;
            i_relay_valid = 1'b0;

            cnt = 0;
            while (!(u_rd_port_ctrl.w_phase == PH_IDLE && !resp_busy)) begin
                next_cycle();
                cnt = cnt + 1;
                if (cnt > TIMEOUT) begin
                    fail_run($sformatf("Timeout: round %0d never returned to idle", r));
                end
            end
            assert (cmd_cnt == exp_q.size()) else
                value_error($sformatf("round %0d: %0d commands seen, %0d expected",
                                      r, cmd_cnt, exp_q.size()));
            assert (o_rd_byte_valid == 1'b0 && o_rd_flag == 1'b0 &&
                    o_rd_queue == '0 && o_rd_byte == '0) else
                value_error("command outputs not cleared in idle");
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- vlog.f
hdl/rd_port_pkg.sv
hdl/rd_desc_if.sv
hdl/rd_cmd_if.sv
hdl/rd_req_capture.sv
hdl/rd_relay_table.sv
hdl/rd_phase_seq.sv
hdl/rd_cmd_issue.sv
hdl/rd_port_ctrl.sv
test/tb_clk_gen.sv
test/tb_rd_port_ctrl.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rd_port_ctrl
FILELIST = vlog.f

OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
